// File: compile.f
verilog/shifter_lab_pkg.sv
verilog/seg_bus_if.sv
verilog/tick_divider.sv
verilog/button_debounce.sv
verilog/shift_control.sv
verilog/barrel_shifter16.sv
verilog/seg7_digit_encode.sv
verilog/seg7_scan8.sv
verilog/shifter_lab_top.sv
sim/tb_shifter_lab.sv

// File: Makefile
# Verilator build and run for the barrel shifter lab

TOP       ?= tb_shifter_lab
FLIST     ?= compile.f
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_shifter_lab.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shifter_lab import shifter_lab_pkg::*; ();

    localparam int TICK_DIV   = 4;
    // Long enough to pass the filter, then the same time released
    localparam int HOLD_CYC   = (DEBOUNCE_SAMPLES + 3) * TICK_DIV;
    // Too short to be accepted
    localparam int BOUNCE_CYC = (DEBOUNCE_SAMPLES - 2) * TICK_DIV;
    localparam int WAIT_LIMIT = 40 * TICK_DIV;
    localparam int NUM_ROWS   = 10;

    // Hex glyphs, gfedcba, active low
    localparam logic [SEG_W-1:0] HEX_SEG [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic                  clk;
    logic                  rst;
    logic [DATA_W-1:0]     sw;
    logic [4:0]            btn;
    logic [7:0]            led;
    logic [SEG_W-1:0]      seg;
    logic [NUM_DIGITS-1:0] an;

    // Stimulus table
    logic [DATA_W-1:0]  row_sw    [NUM_ROWS];
    logic               row_dir   [NUM_ROWS];
    logic               row_rot   [NUM_ROWS];
    logic [SHAMT_W-1:0] row_shamt [NUM_ROWS];

    // Control state as the presses should have left it
    logic               cur_dir;
    logic               cur_rot;
    logic [SHAMT_W-1:0] cur_shamt;
    // Patterns seen per digit during one scan
    logic [SEG_W-1:0]   shown [NUM_DIGITS];
    int seed;
    int errors;
    int checks;
    int tests;

    shifter_lab_top #(
        .TICK_DIV (TICK_DIV)
    ) DUT (
        .clk (clk),
        .rst (rst),
        .sw  (sw),
        .btn (btn),
        .led (led),
        .seg (seg),
        .an  (an)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // At most one digit lit out of reset
    always @(negedge clk) begin
        if (!rst) begin
            assert ($countones(~an) <= 1) else begin
                $display("Fail at %0t: an expected at most one zero got %b", $time, an);
                errors++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    // Bit j takes bit j-amt (left) or j+amt (right), wrap or zero fill
    function automatic logic [DATA_W-1:0] expect_shift(
        input logic [DATA_W-1:0] d,
        input int                amt,
        input logic              right,
        input logic              wrap
    );
        logic [DATA_W-1:0] r;
        int src;
        r = '0;
        for (int j = 0; j < DATA_W; j++) begin
            src = right ? j + amt : j - amt;
            if (src >= 0 && src < DATA_W) begin
                r[j] = d[src];
            end else if (wrap) begin
                r[j] = d[(src + DATA_W) % DATA_W];
            end
        end
        return r;
    endfunction

    function automatic logic [7:0] led_expect();
        return {cur_shamt, cur_rot, cur_dir, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("%s: %s", name, (errors == err_before) ? "ok" : "mismatch");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Buttons
    //////////////////////////////////////////////////////////////////////

    task automatic press_button(input int idx);
        btn[idx] = 1'b1;
        repeat (HOLD_CYC) @(negedge clk);
        btn[idx] = 1'b0;
        repeat (HOLD_CYC) @(negedge clk);
    endtask

    task automatic wait_led();
        int n;
        n = 0;
        while (led !== led_expect() && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (led === led_expect()) else begin
            $display("Timeout: led stayed %h instead of reaching %h", led, led_expect());
            errors++;
        end
    endtask

    // Press whatever differs, step until the high bits agree
    task automatic move_to_state(input logic d, input logic r, input logic [SHAMT_W-1:0] s);
        if (d != cur_dir) begin
            press_button(0);
            cur_dir = ~cur_dir;
            wait_led();
        end
        if (r != cur_rot) begin
            press_button(1);
            cur_rot = ~cur_rot;
            wait_led();
        end
        for (int b = 0; b < 2; b++) begin
            if (s[b] != cur_shamt[b]) begin
                press_button(2 + b);
                cur_shamt[b] = ~cur_shamt[b];
                wait_led();
            end
        end
        while (cur_shamt[3:2] != s[3:2]) begin
            press_button(4);
            cur_shamt[3:2] = cur_shamt[3:2] + 2'd1;
            wait_led();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Display
    //////////////////////////////////////////////////////////////////////

    // Only fresh scan steps count, so old patterns are skipped
    task automatic capture_digits();
        logic [NUM_DIGITS-1:0] seen;
        logic [NUM_DIGITS-1:0] prev_an;
        int n;
        seen = '0;
        prev_an = an;
        n = 0;
        while (seen != '1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (an != prev_an && $countones(~an) == 1) begin
                for (int k = 0; k < NUM_DIGITS; k++) begin
                    if (!an[k]) begin
                        shown[k] = seg;
                        seen[k] = 1'b1;
                    end
                end
            end
            prev_an = an;
        end
        assert (seen == '1) else begin
            $display("Timeout: the scan did not show all eight digits, saw %b", seen);
            errors++;
        end
    endtask

    task automatic check_display();
        logic [DATA_W-1:0] exp_word;
        exp_word = expect_shift(sw, int'(cur_shamt), cur_dir, cur_rot);
        capture_digits();
        for (int k = 0; k < NUM_DIGITS; k++) begin
            if (k < 4) begin
                check_value($sformatf("digit %0d seg", k), 16'(HEX_SEG[exp_word[4*k +: 4]]),
                            16'(shown[k]));
            end else begin
                check_value($sformatf("digit %0d seg", k), 16'(SEG_BLANK), 16'(shown[k]));
            end
        end
    endtask

    task automatic set_row(input int i, input logic [DATA_W-1:0] w, input logic d,
                           input logic r, input logic [SHAMT_W-1:0] s);
        row_sw[i] = w;
        row_dir[i] = d;
        row_rot[i] = r;
        row_shamt[i] = s;
    endtask

    initial begin
        int err_before;
        logic [7:0] led_before;
        seed = 32'h19c0_84e4;
        rst = 1'b1;
        sw = '0;
        btn = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        cur_dir = 1'b0;
        cur_rot = 1'b0;
        cur_shamt = '0;
        // Corner words first, then random ones
        set_row(0, 16'h8001, 1'b0, 1'b0, 4'd0);
        set_row(1, 16'h8001, 1'b0, 1'b0, 4'd1);
        set_row(2, 16'hFFFF, 1'b1, 1'b0, 4'd4);
        set_row(3, 16'h0000, 1'b1, 1'b1, 4'd7);
        set_row(4, 16'h8001, 1'b1, 1'b1, 4'd15);
        set_row(5, 16'($random(seed)), 1'b0, 1'b1, 4'd0);
        set_row(6, 16'($random(seed)), 1'b0, 1'b1, 4'd15);
        set_row(7, 16'($random(seed)), 1'b1, 1'b0, 4'd9);
        set_row(8, 16'($random(seed)), 1'b0, 1'b0, 4'd13);
        set_row(9, 16'($random(seed)), 1'b1, 1'b1, 4'd6);
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // Dark display until the first tick reaches the scanner
        err_before = errors;
        check_value("led", 16'h0000, 16'(led));
        repeat (TICK_DIV) begin
            @(negedge clk);
            check_value("an", 16'h00FF, 16'(an));
        end
        check_display();
        report_test("reset state", err_before);

        for (int i = 0; i < NUM_ROWS; i++) begin
            err_before = errors;
            sw = row_sw[i];
            move_to_state(row_dir[i], row_rot[i], row_shamt[i]);
            check_display();
            report_test($sformatf("row %0d sw=%h dir=%0b rotate=%0b shamt=%0d", i,
                                  row_sw[i], row_dir[i], row_rot[i], row_shamt[i]),
                        err_before);
        end

        // Four steps wrap the high bits back
        err_before = errors;
        led_before = led;
        repeat (4) begin
            press_button(4);
            cur_shamt[3:2] = cur_shamt[3:2] + 2'd1;
            wait_led();
        end
        check_value("led", 16'(led_before), 16'(led));
        report_test("step wrap", err_before);

        // Short bursts on rotate must be filtered out
        err_before = errors;
        led_before = led;
        repeat (4) begin
            btn[1] = 1'b1;
            repeat (BOUNCE_CYC) @(negedge clk);
            btn[1] = 1'b0;
            repeat (BOUNCE_CYC) @(negedge clk);
        end
        repeat (HOLD_CYC) @(negedge clk);
        check_value("led", 16'(led_before), 16'(led));
        report_test("bounce rejection", err_before);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/shifter_lab_top.sv
`timescale 1ns/1ps
`default_nettype none

module shifter_lab_top import shifter_lab_pkg::*; #(
    parameter int TICK_DIV = 100000
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire  [DATA_W-1:0]     sw,
    input  wire  [4:0]            btn,
    output logic [7:0]            led,
    output logic [SEG_W-1:0]      seg,
    output logic [NUM_DIGITS-1:0] an
);

    logic                tick;
    logic [4:0]          press;
    logic                dir;
    logic                rotate;
    logic [SHAMT_W-1:0]  shamt;
    logic [DATA_W-1:0]   result;

    seg_bus_if seg_bus ();

    //////////////////////////////////////////////////////////////////////
    // Timing and buttons
    //////////////////////////////////////////////////////////////////////

    // Shared 1 kHz enable for filters and scan
    tick_divider #(
        .TICK_DIV (TICK_DIV)
    ) u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    // 0 dir, 1 rotate, 2 shamt0, 3 shamt1, 4 step
    for (genvar b = 0; b < 5; b++) begin : g_btn
        button_debounce u_db (
            .clk     (clk),
            .rst     (rst),
            .tick    (tick),
            .btn_raw (btn[b]),
            .press   (press[b])
        );
    end

    shift_control u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .press_dir  (press[0]),
        .press_rot  (press[1]),
        .press_sh0  (press[2]),
        .press_sh1  (press[3]),
        .press_step (press[4]),
        .dir        (dir),
        .rotate     (rotate),
        .shamt      (shamt),
        .led        (led)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath and display
    //////////////////////////////////////////////////////////////////////

    barrel_shifter16 u_shift (
        .data_in  (sw),
        .shamt    (shamt),
        .dir      (dir),
        .rotate   (rotate),
        .data_out (result)
    );

    seg7_digit_encode u_enc (
        .value  (result),
        .digits (seg_bus.source)
    );

    seg7_scan8 u_scan (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .digits (seg_bus.sink),
        .an     (an),
        .seg    (seg)
    );

endmodule

`default_nettype wire

// File: verilog/seg7_scan8.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan8 import shifter_lab_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   tick,
    seg_bus_if.sink               digits,
    output logic [NUM_DIGITS-1:0] an,
    output logic [SEG_W-1:0]      seg
);

    scan_state_e state;
    scan_state_e next_state;

    // Wraps DIGIT7 back to DIGIT0
    assign next_state = scan_state_e'(state + 1'b1);

    //////////////////////////////////////////////////////////////////////
    // Scan register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // Parked on the last digit, first tick lands on DIGIT0
            state <= DIGIT7;
            an    <= '1;
            seg   <= SEG_BLANK;
        end else if (tick) begin
            state <= next_state;
            // Anode and pattern move together
            an    <= ~(NUM_DIGITS'(1) << next_state);
            seg   <= digits.digit[next_state];
        end
    end

    // No two digits lit at once
    a_an_onehot : assert property (
        @(posedge clk) disable iff (rst) $onehot0(~an)
    ) else $error("more than one anode active");

endmodule

`default_nettype wire

// File: verilog/seg7_digit_encode.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_digit_encode import shifter_lab_pkg::*; (
    input  wire  [DATA_W-1:0] value,
    seg_bus_if.source         digits
);

    // Hex glyph, gfedcba, active low
    function automatic logic [SEG_W-1:0] hex_glyph(input logic [3:0] nib);
        logic [SEG_W-1:0] g;
        case (nib)
            4'h0: g = 7'b1000000;
            4'h1: g = 7'b1111001;
            4'h2: g = 7'b0100100;
            4'h3: g = 7'b0110000;
            4'h4: g = 7'b0011001;
            4'h5: g = 7'b0010010;
            4'h6: g = 7'b0000010;
            4'h7: g = 7'b1111000;
            4'h8: g = 7'b0000000;
            4'h9: g = 7'b0010000;
            4'hA: g = 7'b0001000;
            4'hB: g = 7'b0000011;
            4'hC: g = 7'b1000110;
            4'hD: g = 7'b0100001;
            4'hE: g = 7'b0000110;
            default: g = 7'b0001110;
        endcase
        return g;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Digit fan-out
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
        if (i < DATA_W / 4) begin : g_hex
            // Nibble i, least significant on the right
            assign digits.digit[i] = hex_glyph(value[4*i +: 4]);
        end else begin : g_blank
            // Upper digits stay dark
            assign digits.digit[i] = SEG_BLANK;
        end
    end

endmodule

`default_nettype wire

// File: verilog/barrel_shifter16.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter16 import shifter_lab_pkg::*; (
    input  wire  [DATA_W-1:0]  data_in,
    input  wire  [SHAMT_W-1:0] shamt,
    input  wire                dir,
    input  wire                rotate,
    output logic [DATA_W-1:0]  data_out
);

    // One stage: move by amt, zero fill or wrap
    function automatic logic [DATA_W-1:0] shift_by(
        input logic [DATA_W-1:0] v,
        input int                amt,
        input logic              right,
        input logic              wrap
    );
        logic [2*DATA_W-1:0] dbl;
        logic [DATA_W-1:0]   res;
        dbl = {v, v};
        if (right) begin
            // Low half of the doubled word holds the wrapped bits
            res = wrap ? DATA_W'(dbl >> amt) : (v >> amt);
        end else begin
            // High half for left moves
            dbl = dbl << amt;
            res = wrap ? dbl[2*DATA_W-1:DATA_W] : (v << amt);
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Log stages, 1 2 4 8
    //////////////////////////////////////////////////////////////////////

    logic [DATA_W-1:0] stage_data [SHAMT_W+1];

    assign stage_data[0] = data_in;

    for (genvar s = 0; s < SHAMT_W; s++) begin : g_stage
        // Bypass when this amount bit is clear
        assign stage_data[s+1] = shamt[s]
                               ? shift_by(stage_data[s], 1 << s, dir, rotate)
                               : stage_data[s];
    end

    assign data_out = stage_data[SHAMT_W];

endmodule

`default_nettype wire

// File: verilog/shift_control.sv
`timescale 1ns/1ps
`default_nettype none

module shift_control import shifter_lab_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                press_dir,
    input  wire                press_rot,
    input  wire                press_sh0,
    input  wire                press_sh1,
    input  wire                press_step,
    output logic               dir,
    output logic               rotate,
    output logic [SHAMT_W-1:0] shamt,
    output logic [7:0]         led
);

    // Toggled low bits of the amount
    logic [1:0] shamt_lo;
    // Step counter for the high bits, wraps mod 4
    logic [SHAMT_W-3:0] shamt_hi;

    always_ff @(posedge clk) begin
        if (rst) begin
            dir      <= 1'b0;
            rotate   <= 1'b0;
            shamt_lo <= '0;
            shamt_hi <= '0;
        end else begin
            // Each press flips its own bit
            if (press_dir) dir <= ~dir;
            if (press_rot) rotate <= ~rotate;
            if (press_sh0) shamt_lo[0] <= ~shamt_lo[0];
            if (press_sh1) shamt_lo[1] <= ~shamt_lo[1];
            // Centre button steps by 4
            if (press_step) shamt_hi <= shamt_hi + 1'b1;
        end
    end

    assign shamt = {shamt_hi, shamt_lo};

    // LED map: amount, rotate, dir, two dark
    assign led = {shamt, rotate, dir, 2'b00};

endmodule

`default_nettype wire

// File: verilog/button_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module button_debounce import shifter_lab_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  tick,
    input  wire  btn_raw,
    output logic press
);

    //////////////////////////////////////////////////////////////////////
    // Synchroniser
    //////////////////////////////////////////////////////////////////////

    logic sync_q1;
    logic sync_q2;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= btn_raw;
            sync_q2 <= sync_q1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stability filter, sampled on ticks
    //////////////////////////////////////////////////////////////////////

    logic [$clog2(DEBOUNCE_SAMPLES+1)-1:0] stable_cnt;
    logic level;
    logic level_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (tick) begin
            if (sync_q2 == level) begin
                // Bounce back, start over
                stable_cnt <= '0;
            end else if (stable_cnt == DEBOUNCE_SAMPLES - 1) begin
                // Enough equal samples, accept
                level      <= sync_q2;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // Rising edge of the accepted level
    always_ff @(posedge clk) begin
        if (rst) begin
            level_d <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_d <= level;
            press   <= level & ~level_d;
        end
    end

    a_press_pulse : assert property (
        @(posedge clk) disable iff (rst) press |=> !press
    ) else $error("press longer than one cycle");

endmodule

`default_nettype wire

// File: verilog/tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int TICK_DIV = 100000
) (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    // Free-running count, wraps every TICK_DIV clocks
    logic [$clog2(TICK_DIV)-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == TICK_DIV - 1) begin
            // Wrap and strobe for one clock
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // Strobe never stretches into a level
    a_tick_single : assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    ) else $error("tick high for more than one cycle");

endmodule

`default_nettype wire

// File: verilog/seg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface seg_bus_if import shifter_lab_pkg::*; ();

    // Active-low glyph per digit, index 0 is the rightmost digit
    logic [NUM_DIGITS-1:0][SEG_W-1:0] digit;

    // Encoder side drives every pattern
    modport source (
        output digit
    );

    // Scanner side only reads
    modport sink (
        input digit
    );

endinterface

`default_nettype wire

// File: verilog/shifter_lab_pkg.sv
`default_nettype none

package shifter_lab_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////

    // Switch word fed to the shifter
    localparam int DATA_W = 16;

    // One shamt bit per shifter stage (1, 2, 4, 8)
    localparam int SHAMT_W = 4;

    //////////////////////////////////////////////////////////////////////
    // Seven-segment display
    //////////////////////////////////////////////////////////////////////

    // Eight anodes on the board
    localparam int NUM_DIGITS = 8;

    // Segments a..g, no decimal point
    localparam int SEG_W = 7;

    // Active low, so all ones is dark
    localparam logic [SEG_W-1:0] SEG_BLANK = {SEG_W{1'b1}};

    //////////////////////////////////////////////////////////////////////
    // Button filtering
    //////////////////////////////////////////////////////////////////////

    // Equal tick samples before a new level is trusted
    localparam int DEBOUNCE_SAMPLES = 4;

    // Scanner position, one state per digit
    typedef enum logic [$clog2(NUM_DIGITS)-1:0] {
        DIGIT0,
        DIGIT1,
        DIGIT2,
        DIGIT3,
        DIGIT4,
        DIGIT5,
        DIGIT6,
        DIGIT7
    } scan_state_e;

endpackage

`default_nettype wire
